//--- include/accel_macros.svh
`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

// register file geometry
`define ACCEL_ROWS        16
`define ACCEL_LANES       4
`define ACCEL_LANE_W      16
`define ACCEL_MEM_ADDR_W  16

// host command fields
`define ACCEL_OP_MSB      31
`define ACCEL_OP_LSB      28
`define ACCEL_DST_MSB     27
`define ACCEL_DST_LSB     24
`define ACCEL_SRCA_MSB    23
`define ACCEL_SRCA_LSB    20
`define ACCEL_SRCB_MSB    19
`define ACCEL_SRCB_LSB    16
`define ACCEL_ADDR_MSB    15
`define ACCEL_ADDR_LSB    0

`endif

//--- verilog/accel_pkg.sv
`include "accel_macros.svh"

package accel_pkg;

// plain vectors
typedef logic [$clog2(`ACCEL_ROWS)-1:0]           rf_addr_t;
typedef logic [`ACCEL_LANE_W-1:0]                 lane_t;
// lane 0 sits in the low bits
typedef logic [`ACCEL_LANES*`ACCEL_LANE_W-1:0]    row_t;
typedef logic [`ACCEL_MEM_ADDR_W-1:0]             mem_addr_t;
typedef logic [31:0]                              cmd_t;

// host opcodes, codes 7..15 are illegal
typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_LOAD  = 4'd1,
    OP_STORE = 4'd2,
    OP_MOVE  = 4'd3,
    OP_ADD   = 4'd4,
    OP_MAX   = 4'd5,
    OP_MUL   = 4'd6
} opcode_e;

typedef enum logic [1:0] {EU_ADD, EU_MAX, EU_MUL} eu_op_e;

// control unit FSM
typedef enum logic [1:0] {CU_IDLE, CU_ISSUE, CU_WAIT} cu_state_e;

// load/store FSM
typedef enum logic [1:0] {LS_IDLE, LS_REQ, LS_WAIT_DATA} ldst_state_e;

endpackage

//--- verilog/accel_intf.sv
//////////////////////////////
// row copy request
//////////////////////////////
interface rf_move_intf;
    logic                start;
    accel_pkg::rf_addr_t src;
    accel_pkg::rf_addr_t dst;
    logic                done;

    modport ctrl_unit (output start, src, dst, input done);
    modport rf_move (input start, src, dst, output done);
endinterface

//////////////////////////////
// row transfer to/from memory
//////////////////////////////
interface rf_ldst_intf;
    logic                 start;
    logic                 is_store;
    accel_pkg::rf_addr_t  row;
    accel_pkg::mem_addr_t mem_addr;
    logic                 done;

    modport ctrl_unit (output start, is_store, row, mem_addr, input done);
    modport rf_ldst (input start, is_store, row, mem_addr, output done);
endinterface

//////////////////////////////
// EU dispatch
//////////////////////////////
interface eu_ctrl_intf;
    logic                start;
    accel_pkg::eu_op_e   op;
    accel_pkg::rf_addr_t dst;
    accel_pkg::rf_addr_t src_a;
    accel_pkg::rf_addr_t src_b;
    logic                done;

    modport ctrl_unit (output start, op, dst, src_a, src_b, input done);
    modport eu (input start, op, dst, src_a, src_b, output done);
endinterface

//////////////////////////////
// EU access to RF storage
//////////////////////////////
interface rmio_intf;
    accel_pkg::rf_addr_t rd_addr_a;
    accel_pkg::rf_addr_t rd_addr_b;
    // combinational read data
    accel_pkg::row_t     rd_data_a;
    accel_pkg::row_t     rd_data_b;
    logic                wr_en;
    accel_pkg::rf_addr_t wr_addr;
    accel_pkg::row_t     wr_data;

    modport eu (
        output rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
        input  rd_data_a, rd_data_b
    );
    modport rf (
        input  rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
        output rd_data_a, rd_data_b
    );
endinterface

//--- verilog/ctrl_unit.sv
`include "accel_macros.svh"

module ctrl_unit (
    input  wire                 clk,
    input  wire                 i_rst_n,

    input  accel_pkg::cmd_t     i_h2f_pio32,
    input  wire                 i_h2f_write,
    output logic [31:0]         o_f2h_pio32,
    output logic                o_f2h_write,

    rf_move_intf.ctrl_unit      rf_move,
    rf_ldst_intf.ctrl_unit      rf_ldst,
    eu_ctrl_intf.ctrl_unit      eu_ctrl
);

accel_pkg::cu_state_e state;
accel_pkg::cmd_t      cmd_q;
accel_pkg::opcode_e   op;
logic                 op_legal;
logic                 issue;
logic                 engine_done;

logic [15:0] cmd_cnt;
logic exec_done, move_done, ldst_done, cu_done;
logic overrun, illegal;

//////////////////////////////
// decode
//////////////////////////////
assign op    = accel_pkg::opcode_e'(cmd_q[`ACCEL_OP_MSB:`ACCEL_OP_LSB]);
assign issue = (state == accel_pkg::CU_ISSUE);

always_comb begin
    case (op)
        accel_pkg::OP_NOP, accel_pkg::OP_LOAD, accel_pkg::OP_STORE,
        accel_pkg::OP_MOVE, accel_pkg::OP_ADD, accel_pkg::OP_MAX,
        accel_pkg::OP_MUL: op_legal = 1'b1;
        default:           op_legal = 1'b0;
    endcase
end

// MOVE copies src a into dst
assign rf_move.start = issue && (op == accel_pkg::OP_MOVE);
assign rf_move.src   = cmd_q[`ACCEL_SRCA_MSB:`ACCEL_SRCA_LSB];
assign rf_move.dst   = cmd_q[`ACCEL_DST_MSB:`ACCEL_DST_LSB];

// LOAD fills dst, STORE sends out src a
assign rf_ldst.start    = issue && (op == accel_pkg::OP_LOAD || op == accel_pkg::OP_STORE);
assign rf_ldst.is_store = (op == accel_pkg::OP_STORE);
assign rf_ldst.row      = rf_ldst.is_store ? cmd_q[`ACCEL_SRCA_MSB:`ACCEL_SRCA_LSB]
                                           : cmd_q[`ACCEL_DST_MSB:`ACCEL_DST_LSB];
assign rf_ldst.mem_addr = cmd_q[`ACCEL_ADDR_MSB:`ACCEL_ADDR_LSB];

assign eu_ctrl.start = issue && (op == accel_pkg::OP_ADD || op == accel_pkg::OP_MAX ||
                                 op == accel_pkg::OP_MUL);
assign eu_ctrl.dst   = cmd_q[`ACCEL_DST_MSB:`ACCEL_DST_LSB];
assign eu_ctrl.src_a = cmd_q[`ACCEL_SRCA_MSB:`ACCEL_SRCA_LSB];
assign eu_ctrl.src_b = cmd_q[`ACCEL_SRCB_MSB:`ACCEL_SRCB_LSB];

always_comb begin
    case (op)
        accel_pkg::OP_MAX: eu_ctrl.op = accel_pkg::EU_MAX;
        accel_pkg::OP_MUL: eu_ctrl.op = accel_pkg::EU_MUL;
        default:           eu_ctrl.op = accel_pkg::EU_ADD;
    endcase
end

assign engine_done = rf_move.done || rf_ldst.done || eu_ctrl.done;

//////////////////////////////
// command FSM and status
//////////////////////////////
always_ff @(posedge clk) begin
    if (state == accel_pkg::CU_IDLE && i_h2f_write) begin
        cmd_q <= i_h2f_pio32;
    end
end

always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        state       <= accel_pkg::CU_IDLE;
        o_f2h_write <= 1'b0;
        cmd_cnt     <= '0;
        {exec_done, move_done, ldst_done, cu_done} <= '0;
        overrun     <= 1'b0;
        illegal     <= 1'b0;
    end else begin
        o_f2h_write <= 1'b0;
        // writes while busy are dropped
        if (i_h2f_write && state != accel_pkg::CU_IDLE) begin
            overrun <= 1'b1;
        end
        case (state)
            accel_pkg::CU_IDLE: begin
                if (i_h2f_write) begin
                    {exec_done, move_done, ldst_done, cu_done} <= '0;
                    state <= accel_pkg::CU_ISSUE;
                end
            end
            accel_pkg::CU_ISSUE: begin
                if (op_legal && op != accel_pkg::OP_NOP) begin
                    state <= accel_pkg::CU_WAIT;
                end else begin
                    // nop and illegal finish here
                    illegal     <= illegal | ~op_legal;
                    cmd_cnt     <= cmd_cnt + 16'd1;
                    cu_done     <= 1'b1;
                    o_f2h_write <= 1'b1;
                    state       <= accel_pkg::CU_IDLE;
                end
            end
            accel_pkg::CU_WAIT: begin
                if (engine_done) begin
                    exec_done   <= eu_ctrl.done;
                    move_done   <= rf_move.done;
                    ldst_done   <= rf_ldst.done;
                    cmd_cnt     <= cmd_cnt + 16'd1;
                    cu_done     <= 1'b1;
                    o_f2h_write <= 1'b1;
                    state       <= accel_pkg::CU_IDLE;
                end
            end
            default: state <= accel_pkg::CU_IDLE;
        endcase
    end
end

assign o_f2h_pio32 = {state != accel_pkg::CU_IDLE, 9'd0, illegal, overrun,
                      cu_done, ldst_done, move_done, exec_done, cmd_cnt};

endmodule

//--- verilog/rf_wrapper.sv
`include "accel_macros.svh"

module rf_wrapper (
    input  wire                   clk,
    input  wire                   i_rst_n,

    rf_move_intf.rf_move          rf_move,
    rf_ldst_intf.rf_ldst          rf_ldst,
    rmio_intf.rf                  rmio,

    output logic                  o_mem_req,
    output logic                  o_mem_we,
    output accel_pkg::mem_addr_t  o_mem_addr,
    output accel_pkg::row_t       o_mem_wdata,
    input  wire                   i_mem_ready,
    input  accel_pkg::row_t       i_mem_rdata,
    input  wire                   i_mem_rvalid
);

accel_pkg::row_t rows [`ACCEL_ROWS];

logic                rf_we;
accel_pkg::rf_addr_t rf_waddr;
accel_pkg::row_t     rf_wdata;

//////////////////////////////
// move engine
//////////////////////////////
logic                mv_pend;
logic                mv_done;
accel_pkg::rf_addr_t mv_dst;
accel_pkg::row_t     mv_data;

always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        mv_pend <= 1'b0;
        mv_done <= 1'b0;
    end else begin
        mv_pend <= rf_move.start;
        mv_done <= mv_pend;
    end
end

// source row captured on start
always_ff @(posedge clk) begin
    if (rf_move.start) begin
        mv_dst  <= rf_move.dst;
        mv_data <= rows[rf_move.src];
    end
end

assign rf_move.done = mv_done;

//////////////////////////////
// load/store engine
//////////////////////////////
accel_pkg::ldst_state_e ls_state;
accel_pkg::rf_addr_t    ls_row;
logic                   ls_accept;
logic                   ld_wr;

assign o_mem_req = (ls_state == accel_pkg::LS_REQ);
assign ls_accept = o_mem_req && i_mem_ready;
assign ld_wr     = (ls_state == accel_pkg::LS_WAIT_DATA) && i_mem_rvalid;

// store ends on acceptance, load on the returned data
assign rf_ldst.done = (ls_accept && o_mem_we) || ld_wr;

always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        ls_state <= accel_pkg::LS_IDLE;
        o_mem_we <= 1'b0;
    end else begin
        case (ls_state)
            accel_pkg::LS_IDLE: begin
                if (rf_ldst.start) begin
                    o_mem_we <= rf_ldst.is_store;
                    ls_state <= accel_pkg::LS_REQ;
                end
            end
            accel_pkg::LS_REQ: begin
                if (i_mem_ready) begin
                    ls_state <= o_mem_we ? accel_pkg::LS_IDLE : accel_pkg::LS_WAIT_DATA;
                end
            end
            accel_pkg::LS_WAIT_DATA: begin
                if (i_mem_rvalid) begin
                    ls_state <= accel_pkg::LS_IDLE;
                end
            end
            default: ls_state <= accel_pkg::LS_IDLE;
        endcase
    end
end

// request fields hold until the next start
always_ff @(posedge clk) begin
    if (rf_ldst.start) begin
        ls_row      <= rf_ldst.row;
        o_mem_addr  <= rf_ldst.mem_addr;
        o_mem_wdata <= rows[rf_ldst.row];
    end
end

//////////////////////////////
// storage
//////////////////////////////
// load first, then move, then EU
always_comb begin
    rf_we    = 1'b1;
    rf_waddr = rmio.wr_addr;
    rf_wdata = rmio.wr_data;
    if (ld_wr) begin
        rf_waddr = ls_row;
        rf_wdata = i_mem_rdata;
    end else if (mv_pend) begin
        rf_waddr = mv_dst;
        rf_wdata = mv_data;
    end else begin
        rf_we = rmio.wr_en;
    end
end

always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        rows <= '{default: '0};
    end else if (rf_we) begin
        rows[rf_waddr] <= rf_wdata;
    end
end

assign rmio.rd_data_a = rows[rmio.rd_addr_a];
assign rmio.rd_data_b = rows[rmio.rd_addr_b];

endmodule

//--- verilog/eu_top.sv
`include "accel_macros.svh"

module eu_top (
    input  wire         clk,
    input  wire         i_rst_n,

    eu_ctrl_intf.eu     eu_ctrl,
    rmio_intf.eu        rmio
);

accel_pkg::eu_op_e   op_q;
accel_pkg::rf_addr_t dst_q;
accel_pkg::rf_addr_t src_a_q;
accel_pkg::rf_addr_t src_b_q;
accel_pkg::row_t     res;
accel_pkg::row_t     res_q;

// pipeline stage flags
logic rd_vld;
logic wr_vld;
logic done_q;

always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        rd_vld <= 1'b0;
        wr_vld <= 1'b0;
        done_q <= 1'b0;
    end else begin
        rd_vld <= eu_ctrl.start;
        wr_vld <= rd_vld;
        done_q <= wr_vld;
    end
end

always_ff @(posedge clk) begin
    if (eu_ctrl.start) begin
        op_q    <= eu_ctrl.op;
        dst_q   <= eu_ctrl.dst;
        src_a_q <= eu_ctrl.src_a;
        src_b_q <= eu_ctrl.src_b;
    end
    if (rd_vld) begin
        res_q <= res;
    end
end

// per-lane datapath, results wrap to 16 bits
always_comb begin : lane_calc
    accel_pkg::lane_t la;
    accel_pkg::lane_t lb;
    res = '0;
    for (int i = 0; i < `ACCEL_LANES; i++) begin
        la = rmio.rd_data_a[i*`ACCEL_LANE_W +: `ACCEL_LANE_W];
        lb = rmio.rd_data_b[i*`ACCEL_LANE_W +: `ACCEL_LANE_W];
        case (op_q)
            accel_pkg::EU_MAX: res[i*`ACCEL_LANE_W +: `ACCEL_LANE_W] = (la > lb) ? la : lb;
            accel_pkg::EU_MUL: res[i*`ACCEL_LANE_W +: `ACCEL_LANE_W] = la * lb;
            default:           res[i*`ACCEL_LANE_W +: `ACCEL_LANE_W] = la + lb;
        endcase
    end
end

assign rmio.rd_addr_a = src_a_q;
assign rmio.rd_addr_b = src_b_q;
assign rmio.wr_en     = wr_vld;
assign rmio.wr_addr   = dst_q;
assign rmio.wr_data   = res_q;
assign eu_ctrl.done   = done_q;

endmodule

//--- verilog/design_top.sv
module design_top (
    input  wire                   clk,
    input  wire                   i_rst_n,

    // host command port
    input  accel_pkg::cmd_t       i_h2f_pio32,
    input  wire                   i_h2f_write,
    output logic [31:0]           o_f2h_pio32,
    output logic                  o_f2h_write,

    // external memory
    output logic                  o_mem_req,
    output logic                  o_mem_we,
    output accel_pkg::mem_addr_t  o_mem_addr,
    output accel_pkg::row_t       o_mem_wdata,
    input  wire                   i_mem_ready,
    input  accel_pkg::row_t       i_mem_rdata,
    input  wire                   i_mem_rvalid
);

//////////////////////////////
// interfaces
//////////////////////////////
rf_move_intf i_rf_move_intf ();
rf_ldst_intf i_rf_ldst_intf ();
eu_ctrl_intf i_eu_ctrl_intf ();
rmio_intf    i_rmio_intf ();

//////////////////////////////
// control unit
//////////////////////////////
ctrl_unit i_ctrl_unit (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_h2f_pio32 (i_h2f_pio32),
    .i_h2f_write (i_h2f_write),
    .o_f2h_pio32 (o_f2h_pio32),
    .o_f2h_write (o_f2h_write),
    .rf_move     (i_rf_move_intf.ctrl_unit),
    .rf_ldst     (i_rf_ldst_intf.ctrl_unit),
    .eu_ctrl     (i_eu_ctrl_intf.ctrl_unit)
);

//////////////////////////////
// register file
//////////////////////////////
rf_wrapper i_rf_wrapper (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .rf_move      (i_rf_move_intf.rf_move),
    .rf_ldst      (i_rf_ldst_intf.rf_ldst),
    .rmio         (i_rmio_intf.rf),
    .o_mem_req    (o_mem_req),
    .o_mem_we     (o_mem_we),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rdata  (i_mem_rdata),
    .i_mem_rvalid (i_mem_rvalid)
);

//////////////////////////////
// execution unit
//////////////////////////////
eu_top i_eu_top (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .eu_ctrl (i_eu_ctrl_intf.eu),
    .rmio    (i_rmio_intf.eu)
);

endmodule

//--- bench/tb_design_top.sv
module tb_design_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD       = 8;
    localparam int NUM_CMDS         = 40;
    localparam int WORST_CMD_CYCLES = 200;
    // twice the time for reset and every command at its worst latency
    localparam int WATCHDOG_NS = (16 + NUM_CMDS * WORST_CMD_CYCLES) * CLK_PERIOD * 2;

    logic        clk;
    logic        i_rst_n;
    logic [31:0] i_h2f_pio32;
    logic        i_h2f_write;
    logic [31:0] o_f2h_pio32;
    logic        o_f2h_write;
    logic        o_mem_req;
    logic        o_mem_we;
    logic [15:0] o_mem_addr;
    logic [63:0] o_mem_wdata;
    logic        i_mem_ready;
    logic [63:0] i_mem_rdata;
    logic        i_mem_rvalid;

    // memory model state
    logic [63:0] mem_model [0:65535];
    logic        bp_mode;
    logic        rd_busy;
    logic [15:0] rd_addr;
    int          rd_delay;
    logic        req_held;
    logic        held_we;
    logic [15:0] held_addr;
    logic [63:0] held_wdata;
    int          accept_cnt;
    int          stall_cnt;

    // reference model
    logic [63:0] ref_rows [16];
    logic [15:0] ref_count;
    logic        exp_overrun;
    logic        exp_illegal;

    int err_value;
    int err_other;

    design_top dut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_h2f_pio32  (i_h2f_pio32),
        .i_h2f_write  (i_h2f_write),
        .o_f2h_pio32  (o_f2h_pio32),
        .o_f2h_write  (o_f2h_write),
        .o_mem_req    (o_mem_req),
        .o_mem_we     (o_mem_we),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_rvalid (i_mem_rvalid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // reporting
    //////////////////////////////
    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            err_value++;
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        err_other++;
        $display("%s", msg);
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////
    always @(posedge clk) begin
        // unaccepted request must not move
        if (req_held) begin
            check_value("o_mem_req", 64'd1, o_mem_req);
            check_value("o_mem_we", held_we, o_mem_we);
            check_value("o_mem_addr", held_addr, o_mem_addr);
            check_value("o_mem_wdata", held_wdata, o_mem_wdata);
        end
        req_held   = o_mem_req && !i_mem_ready;
        held_we    = o_mem_we;
        held_addr  = o_mem_addr;
        held_wdata = o_mem_wdata;
        if (req_held) begin
            stall_cnt++;
        end
        if (o_mem_req && i_mem_ready) begin
            assert (!rd_busy) else note_failure("memory request while a read is outstanding");
            accept_cnt++;
            if (o_mem_we) begin
                mem_model[o_mem_addr] = o_mem_wdata;
            end else begin
                rd_busy  = 1'b1;
                rd_addr  = o_mem_addr;
                rd_delay = $urandom_range(1, 6);
            end
        end
        #1;
        i_mem_rvalid = 1'b0;
        if (rd_busy) begin
            rd_delay--;
            if (rd_delay == 0) begin
                i_mem_rvalid = 1'b1;
                i_mem_rdata  = mem_model[rd_addr];
                rd_busy      = 1'b0;
            end
        end
        i_mem_ready = bp_mode ? ($urandom_range(0, 7) == 0) : ($urandom_range(0, 3) != 0);
    end

    //////////////////////////////
    // command helpers
    //////////////////////////////
    function automatic logic [31:0] make_cmd(input logic [3:0] op, input logic [3:0] dst,
                                             input logic [3:0] src_a, input logic [3:0] src_b,
                                             input logic [15:0] addr);
        return {op, dst, src_a, src_b, addr};
    endfunction

    function automatic logic [63:0] lane_result(input logic [3:0] op, input logic [63:0] a,
                                                input logic [63:0] b);
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] r;
        logic [63:0] res;
        res = '0;
        for (int i = 0; i < 4; i++) begin
            x = a[i*16 +: 16];
            y = b[i*16 +: 16];
            if (op == accel_pkg::OP_ADD) begin
                r = x + y;
            end else if (op == accel_pkg::OP_MAX) begin
                r = (x > y) ? x : y;
            end else begin
                r = x * y;
            end
            res[i*16 +: 16] = r;
        end
        return res;
    endfunction

    // busy is checked on each falling edge until completion
    task automatic wait_complete(output int latency);
        int cycles;
        @(negedge clk);
        cycles = 1;
        while (!o_f2h_write && cycles <= WORST_CMD_CYCLES) begin
            assert (o_f2h_pio32[31]) else note_failure("busy bit low while a command runs");
            // done flags stay clear once a command is accepted
            check_value("o_f2h_pio32[19:16]", 64'd0, o_f2h_pio32[19:16]);
            @(negedge clk);
            cycles++;
        end
        assert (o_f2h_write) else note_failure("command did not complete in time");
        check_value("o_f2h_pio32[31]", 64'd0, o_f2h_pio32[31]);
        latency = cycles;
    endtask

    task automatic issue_cmd(input logic [31:0] cmd, output int latency);
        @(posedge clk);
        #1;
        i_h2f_pio32 = cmd;
        i_h2f_write = 1'b1;
        @(posedge clk);
        #1;
        i_h2f_write = 1'b0;
        wait_complete(latency);
    endtask

    task automatic check_status(input logic ldst, input logic mv, input logic ex);
        check_value("o_f2h_pio32",
                    {32'd0, 1'b0, 9'd0, exp_illegal, exp_overrun, 1'b1, ldst, mv, ex, ref_count},
                    o_f2h_pio32);
    endtask

    task automatic load_row(input logic [3:0] dst, input logic [15:0] addr);
        int lat;
        ref_rows[dst] = mem_model[addr];
        issue_cmd(make_cmd(accel_pkg::OP_LOAD, dst, 4'd0, 4'd0, addr), lat);
        ref_count++;
        check_status(1'b1, 1'b0, 1'b0);
    endtask

    task automatic store_row(input logic [3:0] src, input logic [15:0] addr);
        int lat;
        issue_cmd(make_cmd(accel_pkg::OP_STORE, 4'd0, src, 4'd0, addr), lat);
        ref_count++;
        check_status(1'b1, 1'b0, 1'b0);
        check_value($sformatf("mem[0x%0h]", addr), ref_rows[src], mem_model[addr]);
    endtask

    task automatic move_row(input logic [3:0] dst, input logic [3:0] src);
        int lat;
        issue_cmd(make_cmd(accel_pkg::OP_MOVE, dst, src, 4'd0, 16'd0), lat);
        ref_rows[dst] = ref_rows[src];
        ref_count++;
        check_value("move latency", 64'd4, lat);
        check_status(1'b0, 1'b1, 1'b0);
    endtask

    task automatic exec_rows(input logic [3:0] op, input logic [3:0] dst,
                             input logic [3:0] a, input logic [3:0] b);
        int lat;
        issue_cmd(make_cmd(op, dst, a, b, 16'd0), lat);
        ref_rows[dst] = lane_result(op, ref_rows[a], ref_rows[b]);
        ref_count++;
        check_value("exec latency", 64'd5, lat);
        check_status(1'b0, 1'b0, 1'b1);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic reset_checks();
        repeat (6) begin
            @(negedge clk);
            check_value("o_f2h_pio32", 64'd0, o_f2h_pio32);
            check_value("o_mem_req", 64'd0, o_mem_req);
            check_value("o_f2h_write", 64'd0, o_f2h_write);
        end
        // rows come out of reset cleared
        store_row(4'd9, 16'h0010);
    endtask

    task automatic round_trip();
        for (int k = 0; k < 4; k++) begin
            mem_model[16'h0100 + k] = {$urandom, $urandom};
            load_row(4'(k + 1), 16'(16'h0100 + k));
        end
        for (int k = 0; k < 4; k++) begin
            store_row(4'(k + 1), 16'(16'h0200 + k));
        end
    endtask

    task automatic copy_rows();
        move_row(4'd6, 4'd1);
        store_row(4'd6, 16'h0300);
        move_row(4'd7, 4'd6);
        store_row(4'd7, 16'h0301);
    endtask

    task automatic lane_ops();
        mem_model[16'h0400] = {$urandom, $urandom};
        // lanes that wrap and overflow
        mem_model[16'h0401] = 64'hffff_8000_0001_7fff;
        load_row(4'd10, 16'h0400);
        load_row(4'd11, 16'h0401);
        exec_rows(accel_pkg::OP_ADD, 4'd12, 4'd10, 4'd11);
        exec_rows(accel_pkg::OP_MAX, 4'd13, 4'd10, 4'd11);
        exec_rows(accel_pkg::OP_MUL, 4'd14, 4'd10, 4'd11);
        store_row(4'd12, 16'h0500);
        store_row(4'd13, 16'h0501);
        store_row(4'd14, 16'h0502);
    endtask

    task automatic back_pressure();
        int stalls_before;
        stalls_before = stall_cnt;
        bp_mode = 1'b1;
        for (int k = 0; k < 3; k++) begin
            mem_model[16'h0600 + k] = {$urandom, $urandom};
            load_row(4'(k + 2), 16'(16'h0600 + k));
        end
        for (int k = 0; k < 3; k++) begin
            store_row(4'(k + 2), 16'(16'h0700 + k));
        end
        bp_mode = 1'b0;
        assert (stall_cnt > stalls_before) else note_failure("no memory stall was seen");
    endtask

    task automatic error_flags();
        int lat;
        int accepts_before;
        accepts_before = accept_cnt;
        // second write lands while the move is in flight
        @(posedge clk);
        #1;
        i_h2f_pio32 = make_cmd(accel_pkg::OP_MOVE, 4'd8, 4'd3, 4'd0, 16'd0);
        i_h2f_write = 1'b1;
        @(posedge clk);
        #1;
        i_h2f_pio32 = make_cmd(accel_pkg::OP_STORE, 4'd0, 4'd3, 4'd0, 16'h0800);
        @(posedge clk);
        #1;
        i_h2f_write = 1'b0;
        wait_complete(lat);
        ref_rows[8] = ref_rows[3];
        ref_count++;
        exp_overrun = 1'b1;
        check_status(1'b0, 1'b1, 1'b0);
        repeat (10) begin
            @(negedge clk);
            assert (!o_f2h_write) else note_failure("dropped command completed anyway");
        end
        check_value("memory accepts", accepts_before, accept_cnt);
        issue_cmd(make_cmd(4'hf, 4'd1, 4'd2, 4'd3, 16'h0900), lat);
        ref_count++;
        exp_illegal = 1'b1;
        check_value("illegal latency", 64'd2, lat);
        check_status(1'b0, 1'b0, 1'b0);
        issue_cmd(make_cmd(accel_pkg::OP_NOP, 4'd0, 4'd0, 4'd0, 16'd0), lat);
        ref_count++;
        check_value("nop latency", 64'd2, lat);
        check_status(1'b0, 1'b0, 1'b0);
        check_value("memory accepts", accepts_before, accept_cnt);
        store_row(4'd8, 16'h0801);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(5251));
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_h2f_pio32  = '0;
        i_h2f_write  = 1'b0;
        i_mem_ready  = 1'b0;
        i_mem_rdata  = '0;
        i_mem_rvalid = 1'b0;
        bp_mode      = 1'b0;
        rd_busy      = 1'b0;
        rd_delay     = 0;
        req_held     = 1'b0;
        accept_cnt   = 0;
        stall_cnt    = 0;
        ref_count    = '0;
        exp_overrun  = 1'b0;
        exp_illegal  = 1'b0;
        err_value    = 0;
        err_other    = 0;
        for (int a = 0; a < 65536; a++) begin
            mem_model[a] = {16'(a), ~16'(a), 16'(a) ^ 16'hc3a5, 16'(a) + 16'h1234};
        end
        for (int r = 0; r < 16; r++) begin
            ref_rows[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        i_rst_n = 1'b1;

        reset_checks();
        round_trip();
        copy_rows();
        lane_ops();
        back_pressure();
        error_flags();

        repeat (4) @(posedge clk);
        $display("check summary: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
verilog/accel_pkg.sv
verilog/accel_intf.sv
verilog/ctrl_unit.sv
verilog/rf_wrapper.sv
verilog/eu_top.sv
verilog/design_top.sv
bench/tb_design_top.sv

//--- Bender.yml
package:
  name: vector_accel

export_include_dirs:
  - include

sources:
  - files:
      - verilog/accel_pkg.sv
      - verilog/accel_intf.sv
      - verilog/ctrl_unit.sv
      - verilog/rf_wrapper.sv
      - verilog/eu_top.sv
      - verilog/design_top.sv
  - target: simulation
    files:
      - bench/tb_design_top.sv
